/* bench/tb_motor_reg.sv */
// Directed testbench of the motor controller register file
// Host strobes driven on the falling edge, motor side outputs and read data checked there

`timescale 1ns/10ps

module tb_motor_reg;

    localparam int N_DRIVE    = 4;
    localparam int N_ROTATION = 4;
    localparam int CLK_PERIOD = 40;
    localparam int N_TESTS    = 6;
    localparam int MAX_CYCLES = 80;   // Upper bound for one test
    localparam int TIMEOUT_NS = N_TESTS * MAX_CYCLES * CLK_PERIOD * 2;

    logic                                           clock;
    logic                                           arst_n;
    logic [motor_regs_pkg::ADDR_W-1:0]              address;
    logic                                           write_en;
    logic [motor_regs_pkg::DATA_W-1:0]              wr_data;
    logic                                           read_en;
    logic [motor_regs_pkg::DATA_W-1:0]              rd_data;
    logic [N_DRIVE-1:0]                             fault, startup_fail;
    logic [N_DRIVE-1:0][motor_regs_pkg::TEMP_W-1:0] adc_temp;
    logic [N_DRIVE-1:0]                             brake, enable, direction;
    logic [N_DRIVE-1:0][motor_regs_pkg::PWM_W-1:0]  pwm;
    logic [N_ROTATION-1:0]                          rot_brake, rot_enable, rot_direction;
    logic [N_ROTATION-1:0]                          update_angle, abort_angle, angle_done;
    logic [N_ROTATION-1:0][motor_regs_pkg::ANGLE_W-1:0] target_angle, current_angle;

    // Expected register contents
    logic [N_DRIVE-1:0][7:0]    drive_ctrl_exp;
    logic [N_ROTATION-1:0][7:0] rot_ctrl_exp;
    logic [N_ROTATION-1:0][7:0] rot_target_exp;

    integer seed        = 32'h3d872801;
    int     error_count = 0;
    int     check_count = 0;

    motor_reg_top #(.N_DRIVE(N_DRIVE), .N_ROTATION(N_ROTATION)) i_motor_reg_top (
        .clock         (clock),
        .arst_n        (arst_n),
        .address       (address),
        .write_en      (write_en),
        .wr_data       (wr_data),
        .read_en       (read_en),
        .rd_data       (rd_data),
        .fault         (fault),
        .startup_fail  (startup_fail),
        .adc_temp      (adc_temp),
        .brake         (brake),
        .enable        (enable),
        .direction     (direction),
        .pwm           (pwm),
        .rot_brake     (rot_brake),
        .rot_enable    (rot_enable),
        .rot_direction (rot_direction),
        .target_angle  (target_angle),
        .update_angle  (update_angle),
        .abort_angle   (abort_angle),
        .current_angle (current_angle),
        .angle_done    (angle_done)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // Drive channel n at 0x04 + 2n, rotation channel n at 0x10 + 4n
    function automatic logic [5:0] drive_addr(int ch, int idx);
        return 6'(4 + 2 * ch + idx);
    endfunction

    function automatic logic [5:0] rot_addr(int ch, int idx);
        return 6'(16 + 4 * ch + idx);
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] %s %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic reg_write(input logic [5:0] addr, input logic [7:0] data);
        address  = addr;
        wr_data  = data;
        write_en = 1'b1;
        @(negedge clock);  // Rising edge in between takes it
        write_en = 1'b0;
    endtask

    task automatic reg_read(input logic [5:0] addr, output logic [7:0] data);
        address = addr;
        read_en = 1'b1;
        @(negedge clock);
        read_en = 1'b0;
        data    = rd_data;  // Held until the next read
    endtask

    // All motor side outputs against the expected registers, pulses idle
    task automatic check_outputs(input string test_name);
        for (int i = 0; i < N_DRIVE; i++) begin
            check_value(test_name, $sformatf("brake[%0d]", i), drive_ctrl_exp[i][7], brake[i]);
            check_value(test_name, $sformatf("enable[%0d]", i), drive_ctrl_exp[i][6], enable[i]);
            check_value(test_name, $sformatf("direction[%0d]", i), drive_ctrl_exp[i][5],
                        direction[i]);
            check_value(test_name, $sformatf("pwm[%0d]", i), drive_ctrl_exp[i][4:0], pwm[i]);
        end
        for (int i = 0; i < N_ROTATION; i++) begin
            check_value(test_name, $sformatf("rot_brake[%0d]", i), rot_ctrl_exp[i][7],
                        rot_brake[i]);
            check_value(test_name, $sformatf("rot_enable[%0d]", i), rot_ctrl_exp[i][6],
                        rot_enable[i]);
            check_value(test_name, $sformatf("rot_direction[%0d]", i), rot_ctrl_exp[i][5],
                        rot_direction[i]);
            check_value(test_name, $sformatf("target_angle[%0d]", i),
                        {rot_ctrl_exp[i][3:0], rot_target_exp[i]}, target_angle[i]);
        end
        check_value(test_name, "update_angle", 0, update_angle);
        check_value(test_name, "abort_angle", 0, abort_angle);
    endtask

    task automatic reset_values();
        logic [7:0] data;
        check_outputs("reset_values");
        check_value("reset_values", "rd_data", 0, rd_data);
        for (int i = 0; i < N_DRIVE; i++) begin
            reg_read(drive_addr(i, 0), data);
            check_value("reset_values", $sformatf("drive control %0d", i), 0, data);
        end
        for (int i = 0; i < N_ROTATION; i++) begin
            reg_read(rot_addr(i, 0), data);
            check_value("reset_values", $sformatf("rotation control %0d", i), 0, data);
            reg_read(rot_addr(i, 1), data);
            check_value("reset_values", $sformatf("rotation target %0d", i), 0, data);
        end
    endtask

    task automatic drive_control_status();
        logic [7:0] data;
        for (int i = 0; i < N_DRIVE; i++) begin
            drive_ctrl_exp[i] = 8'(next_rand());
            reg_write(drive_addr(i, 0), drive_ctrl_exp[i]);
        end
        check_outputs("drive_control");  // Also shows no spill into other channels
        for (int i = 0; i < N_DRIVE; i++) begin
            reg_read(drive_addr(i, 0), data);
            check_value("drive_control", $sformatf("readback %0d", i), drive_ctrl_exp[i], data);
        end
        fault        = 4'(next_rand());
        startup_fail = 4'(next_rand());
        adc_temp     = 24'(next_rand());
        repeat (2) @(negedge clock);  // Status sampled every clock
        for (int i = 0; i < N_DRIVE; i++) begin
            reg_read(drive_addr(i, 1), data);
            check_value("drive_status", $sformatf("status %0d", i),
                        {fault[i], startup_fail[i], adc_temp[i]}, data);
        end
    endtask

    task automatic broadcast_writes();
        logic [7:0] data;
        logic [7:0] value;
        logic [5:0] unmapped [4] = '{6'h00, 6'h0c, 6'h2a, 6'h3f};
        value = 8'(next_rand());
        reg_write(6'h03, value);  // Drive controls only
        for (int i = 0; i < N_DRIVE; i++)
            drive_ctrl_exp[i] = value;
        check_outputs("broadcast_drive");
        value = 8'(next_rand());
        reg_write(6'h02, value);  // Rotation controls only
        for (int i = 0; i < N_ROTATION; i++)
            rot_ctrl_exp[i] = value;
        check_outputs("broadcast_rotation");
        value = 8'(next_rand());
        reg_write(6'h01, value);
        for (int i = 0; i < N_DRIVE; i++)
            drive_ctrl_exp[i] = value;
        for (int i = 0; i < N_ROTATION; i++)
            rot_ctrl_exp[i] = value;
        check_outputs("broadcast_all");
        foreach (unmapped[k]) begin
            reg_write(unmapped[k], 8'(next_rand()));
            check_outputs("unmapped");
            reg_read(unmapped[k], data);
            check_value("unmapped", $sformatf("read 0x%0h", unmapped[k]), 0, data);
        end
    endtask

    task automatic rotation_target();
        logic [7:0] data;
        for (int i = 0; i < N_ROTATION; i++) begin
            rot_ctrl_exp[i]   = 8'(next_rand());
            rot_target_exp[i] = 8'(next_rand());
            reg_write(rot_addr(i, 0), rot_ctrl_exp[i]);
            reg_write(rot_addr(i, 1), rot_target_exp[i]);
        end
        check_outputs("rotation_target");
        for (int i = 0; i < N_ROTATION; i++) begin
            reg_read(rot_addr(i, 0), data);
            check_value("rotation_target", $sformatf("control %0d", i), rot_ctrl_exp[i], data);
            reg_read(rot_addr(i, 1), data);
            check_value("rotation_target", $sformatf("target %0d", i), rot_target_exp[i], data);
        end
    endtask

    task automatic cmd_pulses();
        motor_regs_pkg::angle_cmd_u cmd;
        logic [1:0]                 kind;
        for (int i = 0; i < N_ROTATION; i++) begin
            for (int k = 1; k < 4; k++) begin
                kind            = 2'(k);      // Bit 0 update, bit 1 abort
                cmd             = 8'(next_rand());
                cmd.wr.snapshot = 1'b0;
                cmd.wr.update   = kind[0];
                cmd.wr.abort    = kind[1];
                reg_write(rot_addr(i, 3), cmd);
                check_value("cmd_pulses", $sformatf("update_angle ch%0d code %0d", i, k),
                            32'(kind[0]) << i, update_angle);
                check_value("cmd_pulses", $sformatf("abort_angle ch%0d code %0d", i, k),
                            32'(kind[1]) << i, abort_angle);
                @(negedge clock);
                check_outputs("cmd_pulses");  // One cycle only
            end
        end
    endtask

    task automatic angle_snapshot();
        motor_regs_pkg::angle_cmd_u cmd;
        logic [11:0]                angle;
        logic [7:0]                 data;
        angle_done = 4'(next_rand());
        for (int i = 0; i < N_ROTATION; i++) begin
            angle = 12'(next_rand());
            for (int j = 0; j < N_ROTATION; j++)
                current_angle[j] = 12'(next_rand());
            current_angle[i] = angle;
            cmd              = '0;
            cmd.wr.snapshot  = 1'b1;
            reg_write(rot_addr(i, 3), cmd);
            check_value("angle_snapshot", "update_angle", 0, update_angle);
            current_angle[i] = ~angle;  // Must not reach the snapshot
            @(negedge clock);
            reg_read(rot_addr(i, 2), data);
            check_value("angle_snapshot", $sformatf("current %0d", i), angle[7:0], data);
            reg_read(rot_addr(i, 3), data);
            check_value("angle_snapshot", $sformatf("cmd %0d", i),
                        {angle_done[i], 3'b000, angle[11:8]}, data);
        end
    endtask

    initial begin
        clock          = 1'b0;
        arst_n         = 1'b0;
        address        = '0;
        write_en       = 1'b0;
        wr_data        = '0;
        read_en        = 1'b0;
        fault          = '0;
        startup_fail   = '0;
        adc_temp       = '0;
        current_angle  = '0;
        angle_done     = '0;
        drive_ctrl_exp = '0;
        rot_ctrl_exp   = '0;
        rot_target_exp = '0;
        repeat (3) @(negedge clock);  // Three rising edges in reset
        arst_n = 1'b1;
        reset_values();
        drive_control_status();
        broadcast_writes();
        rotation_target();
        cmd_pulses();
        angle_snapshot();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* common/bank_bus_if.sv */
// Decoded write and read selection from the address decoder to one register bank
// Decoder side drives selection, bank side returns read data

`timescale 1ns/10ps

interface bank_bus_if #(
    parameter int CHANNELS = 4
) ();

    localparam int CH_W = motor_regs_pkg::idx_w(CHANNELS);

    logic [CHANNELS-1:0]                 wr_mask;  // One bit per written channel
    logic [1:0]                          wr_idx;   // Word within channel
    logic [motor_regs_pkg::DATA_W-1:0]   wr_data;
    logic [CH_W-1:0]                     rd_ch;
    logic [1:0]                          rd_idx;
    logic [motor_regs_pkg::DATA_W-1:0]   rd_data;  // Combinational from bank

    modport decoder (
        output wr_mask, wr_idx, wr_data, rd_ch, rd_idx,
        input  rd_data
    );

    modport bank (
        input  wr_mask, wr_idx, wr_data, rd_ch, rd_idx,
        output rd_data
    );

endinterface

/* common/motor_regs_pkg.sv */
// Shared widths, register map and field positions of the motor controller registers
// Every RTL file refers to these as motor_regs_pkg::name

package motor_regs_pkg;

    localparam int ADDR_W  = 6;    // Host address bus
    localparam int DATA_W  = 8;    // Register width
    localparam int ANGLE_W = 12;
    localparam int PWM_W   = 5;
    localparam int TEMP_W  = 6;

    // Broadcast addresses, 0x00 is reserved
    localparam logic [ADDR_W-1:0] ADDR_BCAST_ALL   = 6'h01;
    localparam logic [ADDR_W-1:0] ADDR_BCAST_ROT   = 6'h02;
    localparam logic [ADDR_W-1:0] ADDR_BCAST_DRIVE = 6'h03;

    // Drive channels from 0x04, two words each
    localparam logic [ADDR_W-1:0] DRIVE_BASE   = 6'h04;
    localparam int                DRIVE_STRIDE = 2;
    // Rotation channels from 0x10, four words each
    localparam logic [ADDR_W-1:0] ROT_BASE     = 6'h10;
    localparam int                ROT_STRIDE   = 4;

    // Word index inside one channel
    localparam logic [1:0] DRIVE_REG_CONTROL = 2'd0;
    localparam logic [1:0] DRIVE_REG_STATUS  = 2'd1;
    localparam logic [1:0] ROT_REG_CONTROL   = 2'd0;
    localparam logic [1:0] ROT_REG_TARGET    = 2'd1;
    localparam logic [1:0] ROT_REG_CURRENT   = 2'd2;
    localparam logic [1:0] ROT_REG_CMD       = 2'd3;

    // Control byte bits common to both banks
    localparam int BIT_BRAKE     = 7;
    localparam int BIT_ENABLE    = 6;
    localparam int BIT_DIRECTION = 5;

    // Channel index width, at least one bit
    function automatic int idx_w(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // Angle command word as the host writes it
    typedef struct packed {
        logic       unused_hi;
        logic       snapshot;    // Capture current angle
        logic       update;      // Start move to target
        logic       abort;       // Stop the move
        logic [3:0] unused_lo;
    } angle_cmd_wr_s;

    // Same word as the host reads it back
    typedef struct packed {
        logic       angle_done;
        logic [2:0] zero;
        logic [3:0] snap_hi;     // Snapshot bits 11:8
    } angle_status_rd_s;

    typedef union packed {
        angle_cmd_wr_s    wr;
        angle_status_rd_s rd;
    } angle_cmd_u;

endpackage

/* drive/drive_bank.sv */
// Drive motor registers, one control and one status word per channel
// Control drives brake, enable, direction and PWM, status samples the motor every clock

`timescale 1ns/10ps

module drive_bank #(
    parameter int N_DRIVE = 4
) (
    input  logic                                           clock,
    input  logic                                           arst_n,
    bank_bus_if.bank                                       bus,
    input  logic [N_DRIVE-1:0]                             fault,
    input  logic [N_DRIVE-1:0]                             startup_fail,
    input  logic [N_DRIVE-1:0][motor_regs_pkg::TEMP_W-1:0] adc_temp,
    output logic [N_DRIVE-1:0]                             brake,
    output logic [N_DRIVE-1:0]                             enable,
    output logic [N_DRIVE-1:0]                             direction,
    output logic [N_DRIVE-1:0][motor_regs_pkg::PWM_W-1:0]  pwm
);

    logic [N_DRIVE-1:0][motor_regs_pkg::DATA_W-1:0] ctrl;    // Host written
    logic [N_DRIVE-1:0][motor_regs_pkg::DATA_W-1:0] status;  // {fault, startup_fail, temp}

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
        end else begin
            for (int i = 0; i < N_DRIVE; i++) begin
                // Status word is read only, writes to it drop
                if (bus.wr_mask[i] && bus.wr_idx == motor_regs_pkg::DRIVE_REG_CONTROL)
                    ctrl[i] <= bus.wr_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < N_DRIVE; i++)
            status[i] <= {fault[i], startup_fail[i], adc_temp[i]};
    end

    for (genvar i = 0; i < N_DRIVE; i++) begin : g_out
        assign brake[i]     = ctrl[i][motor_regs_pkg::BIT_BRAKE];
        assign enable[i]    = ctrl[i][motor_regs_pkg::BIT_ENABLE];
        assign direction[i] = ctrl[i][motor_regs_pkg::BIT_DIRECTION];
        assign pwm[i]       = ctrl[i][motor_regs_pkg::PWM_W-1:0];  // Duty in low bits
    end

    always_comb begin
        bus.rd_data = '0;
        if (int'(bus.rd_ch) < N_DRIVE) begin  // Guard for non power of two counts
            case (bus.rd_idx)
                motor_regs_pkg::DRIVE_REG_CONTROL: bus.rd_data = ctrl[bus.rd_ch];
                motor_regs_pkg::DRIVE_REG_STATUS:  bus.rd_data = status[bus.rd_ch];
                default:                           bus.rd_data = '0;
            endcase
        end
    end

endmodule

/* rotation/rotation_bank.sv */
// Swerve rotation motor registers, four words per channel
// Holds control and target angle, fires update and abort pulses, snapshots the angle

`timescale 1ns/10ps

module rotation_bank #(
    parameter int N_ROTATION = 4
) (
    input  logic                                               clock,
    input  logic                                               arst_n,
    bank_bus_if.bank                                           bus,
    input  logic [N_ROTATION-1:0][motor_regs_pkg::ANGLE_W-1:0] current_angle,
    input  logic [N_ROTATION-1:0]                              angle_done,
    output logic [N_ROTATION-1:0]                              rot_brake,
    output logic [N_ROTATION-1:0]                              rot_enable,
    output logic [N_ROTATION-1:0]                              rot_direction,
    output logic [N_ROTATION-1:0][motor_regs_pkg::ANGLE_W-1:0] target_angle,
    output logic [N_ROTATION-1:0]                              update_angle,
    output logic [N_ROTATION-1:0]                              abort_angle
);

    localparam int HI_W = motor_regs_pkg::ANGLE_W - motor_regs_pkg::DATA_W;  // Angle high bits

    logic [N_ROTATION-1:0][motor_regs_pkg::DATA_W-1:0]  ctrl;    // Low nibble is angle 11:8
    logic [N_ROTATION-1:0][motor_regs_pkg::DATA_W-1:0]  target;  // Angle 7:0
    logic [N_ROTATION-1:0][motor_regs_pkg::ANGLE_W-1:0] snap;
    logic [N_ROTATION-1:0]                              done_q;
    logic [N_ROTATION-1:0]                              cmd_hit;  // CMD word written this cycle
    motor_regs_pkg::angle_cmd_u                         cmd_wr;
    motor_regs_pkg::angle_cmd_u                         cmd_rd;

    assign cmd_wr = bus.wr_data;

    always_comb begin
        for (int i = 0; i < N_ROTATION; i++)
            cmd_hit[i] = bus.wr_mask[i] && bus.wr_idx == motor_regs_pkg::ROT_REG_CMD;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl         <= '0;
            target       <= '0;
            snap         <= '0;
            update_angle <= '0;
            abort_angle  <= '0;
        end else begin
            for (int i = 0; i < N_ROTATION; i++) begin
                if (bus.wr_mask[i] && bus.wr_idx == motor_regs_pkg::ROT_REG_CONTROL)
                    ctrl[i] <= bus.wr_data;
                if (bus.wr_mask[i] && bus.wr_idx == motor_regs_pkg::ROT_REG_TARGET)
                    target[i] <= bus.wr_data;
                // Frozen copy so both halves read back consistent
                if (cmd_hit[i] && cmd_wr.wr.snapshot)
                    snap[i] <= current_angle[i];
                // Pulses last exactly one cycle
                update_angle[i] <= cmd_hit[i] && cmd_wr.wr.update;
                abort_angle[i]  <= cmd_hit[i] && cmd_wr.wr.abort;
            end
        end
    end

    always_ff @(posedge clock) begin
        done_q <= angle_done;
    end

    for (genvar i = 0; i < N_ROTATION; i++) begin : g_out
        assign rot_brake[i]     = ctrl[i][motor_regs_pkg::BIT_BRAKE];
        assign rot_enable[i]    = ctrl[i][motor_regs_pkg::BIT_ENABLE];
        assign rot_direction[i] = ctrl[i][motor_regs_pkg::BIT_DIRECTION];
        assign target_angle[i]  = {ctrl[i][HI_W-1:0], target[i]};
    end

    always_comb begin
        cmd_rd      = '0;
        bus.rd_data = '0;
        if (int'(bus.rd_ch) < N_ROTATION) begin
            cmd_rd.rd.angle_done = done_q[bus.rd_ch];
            cmd_rd.rd.zero       = '0;
            cmd_rd.rd.snap_hi    = snap[bus.rd_ch][motor_regs_pkg::ANGLE_W-1:motor_regs_pkg::DATA_W];
            case (bus.rd_idx)
                motor_regs_pkg::ROT_REG_CONTROL: bus.rd_data = ctrl[bus.rd_ch];
                motor_regs_pkg::ROT_REG_TARGET:  bus.rd_data = target[bus.rd_ch];
                motor_regs_pkg::ROT_REG_CURRENT: begin
                    bus.rd_data = snap[bus.rd_ch][motor_regs_pkg::DATA_W-1:0];  // Low byte
                end
                default:                         bus.rd_data = cmd_rd;
            endcase
        end
    end

    // Each pulse needs a CMD write to that channel alone at the previous edge
    a_update_after_cmd: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(update_angle) && (update_angle & ~$past(cmd_hit)) == '0);
    a_abort_after_cmd: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(abort_angle) && (abort_angle & ~$past(cmd_hit)) == '0);

endmodule

/* rtl/motor_reg_top.sv */
// Register file of the motor controller, host bus on one side, motor signals on the other
// Channel counts set here and passed down to decoder and banks

`timescale 1ns/10ps

module motor_reg_top #(
    parameter int N_DRIVE    = 4,  // Up to 6
    parameter int N_ROTATION = 4   // Up to 12
) (
    input  logic                                 clock,
    input  logic                                 arst_n,
    input  logic [motor_regs_pkg::ADDR_W-1:0]    address,
    input  logic                                 write_en,
    input  logic [motor_regs_pkg::DATA_W-1:0]    wr_data,
    input  logic                                 read_en,
    output logic [motor_regs_pkg::DATA_W-1:0]    rd_data,

    // Drive motors
    input  logic [N_DRIVE-1:0]                             fault,
    input  logic [N_DRIVE-1:0]                             startup_fail,
    input  logic [N_DRIVE-1:0][motor_regs_pkg::TEMP_W-1:0] adc_temp,
    output logic [N_DRIVE-1:0]                             brake,
    output logic [N_DRIVE-1:0]                             enable,
    output logic [N_DRIVE-1:0]                             direction,
    output logic [N_DRIVE-1:0][motor_regs_pkg::PWM_W-1:0]  pwm,

    // Swerve rotation motors
    output logic [N_ROTATION-1:0]                              rot_brake,
    output logic [N_ROTATION-1:0]                              rot_enable,
    output logic [N_ROTATION-1:0]                              rot_direction,
    output logic [N_ROTATION-1:0][motor_regs_pkg::ANGLE_W-1:0] target_angle,
    output logic [N_ROTATION-1:0]                              update_angle,
    output logic [N_ROTATION-1:0]                              abort_angle,
    input  logic [N_ROTATION-1:0][motor_regs_pkg::ANGLE_W-1:0] current_angle,
    input  logic [N_ROTATION-1:0]                              angle_done
);

    bank_bus_if #(.CHANNELS(N_DRIVE))    drive_bus ();
    bank_bus_if #(.CHANNELS(N_ROTATION)) rot_bus ();

    reg_decoder #(.N_DRIVE(N_DRIVE), .N_ROTATION(N_ROTATION)) i_reg_decoder (
        .clock     (clock),
        .arst_n    (arst_n),
        .address   (address),
        .write_en  (write_en),
        .wr_data   (wr_data),
        .read_en   (read_en),
        .rd_data   (rd_data),
        .drive_bus (drive_bus.decoder),
        .rot_bus   (rot_bus.decoder)
    );

    drive_bank #(.N_DRIVE(N_DRIVE)) i_drive_bank (
        .clock        (clock),
        .arst_n       (arst_n),
        .bus          (drive_bus.bank),
        .fault        (fault),
        .startup_fail (startup_fail),
        .adc_temp     (adc_temp),
        .brake        (brake),
        .enable       (enable),
        .direction    (direction),
        .pwm          (pwm)
    );

    rotation_bank #(.N_ROTATION(N_ROTATION)) i_rotation_bank (
        .clock         (clock),
        .arst_n        (arst_n),
        .bus           (rot_bus.bank),
        .current_angle (current_angle),
        .angle_done    (angle_done),
        .rot_brake     (rot_brake),
        .rot_enable    (rot_enable),
        .rot_direction (rot_direction),
        .target_angle  (target_angle),
        .update_angle  (update_angle),
        .abort_angle   (abort_angle)
    );

endmodule

/* rtl/reg_decoder.sv */
// Address decoder of the register file, turns host strobes into per bank selections
// Expands broadcasts and registers read data on read_en

`timescale 1ns/10ps

module reg_decoder #(
    parameter int N_DRIVE    = 4,
    parameter int N_ROTATION = 4
) (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic [motor_regs_pkg::ADDR_W-1:0] address,
    input  logic                              write_en,
    input  logic [motor_regs_pkg::DATA_W-1:0] wr_data,
    input  logic                              read_en,
    output logic [motor_regs_pkg::DATA_W-1:0] rd_data,
    bank_bus_if.decoder                       drive_bus,
    bank_bus_if.decoder                       rot_bus
);

    localparam int D_CH_W = motor_regs_pkg::idx_w(N_DRIVE);
    localparam int R_CH_W = motor_regs_pkg::idx_w(N_ROTATION);
    // One past the last address of each bank, may reach 64
    localparam int DRIVE_END = int'(motor_regs_pkg::DRIVE_BASE)
                               + motor_regs_pkg::DRIVE_STRIDE * N_DRIVE;
    localparam int ROT_END   = int'(motor_regs_pkg::ROT_BASE)
                               + motor_regs_pkg::ROT_STRIDE * N_ROTATION;

    logic [motor_regs_pkg::ADDR_W-1:0] drive_off, rot_off;  // Offset into bank
    logic                              drive_hit, rot_hit;
    logic                              bcast_drive, bcast_rot;
    logic [D_CH_W-1:0]                 drive_ch;
    logic [R_CH_W-1:0]                 rot_ch;
    logic [1:0]                        drive_idx, rot_idx;

    always_comb begin
        drive_off   = address - motor_regs_pkg::DRIVE_BASE;
        rot_off     = address - motor_regs_pkg::ROT_BASE;
        drive_hit   = address >= motor_regs_pkg::DRIVE_BASE && int'(address) < DRIVE_END;
        rot_hit     = address >= motor_regs_pkg::ROT_BASE && int'(address) < ROT_END;
        bcast_drive = address == motor_regs_pkg::ADDR_BCAST_ALL
                      || address == motor_regs_pkg::ADDR_BCAST_DRIVE;
        bcast_rot   = address == motor_regs_pkg::ADDR_BCAST_ALL
                      || address == motor_regs_pkg::ADDR_BCAST_ROT;
        drive_ch    = D_CH_W'(drive_off / motor_regs_pkg::DRIVE_STRIDE);
        drive_idx   = 2'(drive_off % motor_regs_pkg::DRIVE_STRIDE);
        rot_ch      = R_CH_W'(rot_off / motor_regs_pkg::ROT_STRIDE);
        rot_idx     = 2'(rot_off % motor_regs_pkg::ROT_STRIDE);
    end

    // Write selection, broadcasts hit every channel of the bank
    always_comb begin
        for (int i = 0; i < N_DRIVE; i++) begin
            drive_bus.wr_mask[i] = write_en && (bcast_drive || (drive_hit && int'(drive_ch) == i));
        end
        for (int i = 0; i < N_ROTATION; i++) begin
            rot_bus.wr_mask[i] = write_en && (bcast_rot || (rot_hit && int'(rot_ch) == i));
        end
        drive_bus.wr_idx  = bcast_drive ? motor_regs_pkg::DRIVE_REG_CONTROL : drive_idx;
        rot_bus.wr_idx    = bcast_rot ? motor_regs_pkg::ROT_REG_CONTROL : rot_idx;
        drive_bus.wr_data = wr_data;
        rot_bus.wr_data   = wr_data;
    end

    // Read selection, the bank answers in the same cycle
    assign drive_bus.rd_ch  = drive_ch;
    assign drive_bus.rd_idx = drive_idx;
    assign rot_bus.rd_ch    = rot_ch;
    assign rot_bus.rd_idx   = rot_idx;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            if (drive_hit)
                rd_data <= drive_bus.rd_data;
            else if (rot_hit)
                rd_data <= rot_bus.rd_data;
            else
                rd_data <= '0;  // Reserved, broadcast or unmapped
        end
    end

    // Only the global broadcast may write into both banks at once
    a_one_bank_per_write: assert property (@(posedge clock) disable iff (!arst_n)
        (|drive_bus.wr_mask && |rot_bus.wr_mask) |-> address == motor_regs_pkg::ADDR_BCAST_ALL);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the register file testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_motor_reg \
    -Mdir "$BUILD_DIR" -o tb_motor_reg

"$BUILD_DIR/tb_motor_reg" | tee "$LOG_FILE"

if grep -q "Finished with errors" "$LOG_FILE"; then
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi
echo "Simulation passed"

/* verilog.f */
common/motor_regs_pkg.sv
common/bank_bus_if.sv
rtl/reg_decoder.sv
drive/drive_bank.sv
rotation/rotation_bank.sv
rtl/motor_reg_top.sv
bench/tb_motor_reg.sv
